// File: design/lcd_bus_writer.sv
// 8080 write strobe generator for accepted bus words
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_bus_writer (
    input  logic        pclk,
    input  logic        rst_n_i,
    lcd_word_if.snk     word,
    output logic        lcd_cs_n_o,
    output logic        lcd_wr_n_o,
    output logic        lcd_rs_o,
    output logic [15:0] lcd_db_o
);

    localparam int TOTAL = `LCD_WR_LOW_CYC + `LCD_WR_HIGH_CYC;
    localparam int PH_W  = $clog2(TOTAL);

    logic [PH_W-1:0] phase; // cycles left in the current strobe
    logic            xfer;

    // last high cycle counts as idle so words go back to back
    assign word.ready = (phase == '0);
    assign xfer       = word.valid && word.ready;

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase      <= '0;
            lcd_cs_n_o <= 1'b1;
            lcd_wr_n_o <= 1'b1;
        end else if (xfer) begin
            phase      <= PH_W'(TOTAL - 1);
            lcd_cs_n_o <= 1'b0;
            lcd_wr_n_o <= 1'b0;
        end else if (phase != '0) begin
            phase <= phase - 1'b1;
            if (phase == PH_W'(`LCD_WR_HIGH_CYC)) begin
                lcd_wr_n_o <= 1'b1; // panel latches here
            end
        end else begin
            lcd_cs_n_o <= 1'b1; // nothing pending
        end
    end

    // rs and db held for the whole strobe
    always_ff @(posedge pclk) begin
        if (xfer) begin
            lcd_rs_o <= word.rs;
            lcd_db_o <= word.data;
        end
    end

endmodule

// File: design/lcd_cfg_if.sv
// interface for window, color, start and status between register block and sequencer
`timescale 1ns/100ps
`include "lcd_defines.svh"

interface lcd_cfg_if;

    logic [`LCD_COORD_W-1:0] x0;
    logic [`LCD_COORD_W-1:0] x1;
    logic [`LCD_COORD_W-1:0] y0;
    logic [`LCD_COORD_W-1:0] y1;
    logic [15:0]             color;
    logic                    start;      // one cycle pulse
    logic                    busy;       // frame in progress
    logic                    frame_done; // one cycle pulse at end of frame

    modport regs (
        output x0,
        output x1,
        output y0,
        output y1,
        output color,
        output start,
        input  busy,
        input  frame_done
    );

    modport seq (
        input  x0,
        input  x1,
        input  y0,
        input  y1,
        input  color,
        input  start,
        output busy,
        output frame_done
    );

endinterface

// File: design/lcd_defines.svh
// register map, wr strobe widths, coordinate width and panel command codes
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// one screen coordinate
`define LCD_COORD_W 10

// host register map
`define LCD_ADDR_X0     4'd0
`define LCD_ADDR_X1     4'd1
`define LCD_ADDR_Y0     4'd2
`define LCD_ADDR_Y1     4'd3
`define LCD_ADDR_COLOR  4'd4
`define LCD_ADDR_CTRL   4'd5 // bit 0 starts a frame
`define LCD_ADDR_STATUS 4'd6 // busy in bit 0, frame count in 31:16

// 8080 write strobe shape, in pclk cycles
`define LCD_WR_LOW_CYC  2
`define LCD_WR_HIGH_CYC 2

// panel commands sent with rs low
`define LCD_CMD_COL   16'h002A // column address set
`define LCD_CMD_ROW   16'h002B // row address set
`define LCD_CMD_MEMWR 16'h002C // memory write, pixels follow

`endif

// File: design/lcd_pkg.sv
// sequencer state enum and host register access enum
package lcd_pkg;

    // window commands, their parameters, then the pixel stream
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        COL_CMD = 3'd1,
        COL_PAR = 3'd2, // x0 then x1
        ROW_CMD = 3'd3,
        ROW_PAR = 3'd4, // y0 then y1
        MEM_CMD = 3'd5,
        PIXELS  = 3'd6,
        DONE    = 3'd7
    } seq_state_t;

    // kind of host register access
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } reg_op_t;

endpackage

// File: design/lcd_regs.sv
// host register block with window, color, start pulse, busy stall and frame counter
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_regs (
    input  logic             pclk,
    input  logic             rst_n_i,
    input  logic             reg_valid_i,
    input  lcd_pkg::reg_op_t reg_op_i,
    input  logic [3:0]       reg_addr_i,
    input  logic [31:0]      reg_wdata_i,
    output logic             reg_ready_o,
    output logic [31:0]      reg_rdata_o,
    lcd_cfg_if.regs          cfg
);

    logic [`LCD_COORD_W-1:0] x0_q;
    logic [`LCD_COORD_W-1:0] x1_q;
    logic [`LCD_COORD_W-1:0] y0_q;
    logic [`LCD_COORD_W-1:0] y1_q;
    logic [15:0]             color_q;
    logic                    start_q;
    logic [15:0]             frame_cnt;
    logic                    is_write;
    logic                    cfg_write; // write to window, color or ctrl
    logic                    wr_fire;

    assign is_write  = (reg_op_i == lcd_pkg::OP_WRITE);
    assign cfg_write = is_write && (reg_addr_i <= `LCD_ADDR_CTRL);

    // hold config writes off while a frame draws
    assign reg_ready_o = !(cfg.busy && cfg_write);
    assign wr_fire     = reg_valid_i && reg_ready_o && is_write;

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            x0_q    <= '0;
            x1_q    <= '0;
            y0_q    <= '0;
            y1_q    <= '0;
            color_q <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= wr_fire && (reg_addr_i == `LCD_ADDR_CTRL) && reg_wdata_i[0];
            if (wr_fire) begin
                case (reg_addr_i)
                    `LCD_ADDR_X0:    x0_q    <= reg_wdata_i[`LCD_COORD_W-1:0];
                    `LCD_ADDR_X1:    x1_q    <= reg_wdata_i[`LCD_COORD_W-1:0];
                    `LCD_ADDR_Y0:    y0_q    <= reg_wdata_i[`LCD_COORD_W-1:0];
                    `LCD_ADDR_Y1:    y1_q    <= reg_wdata_i[`LCD_COORD_W-1:0];
                    `LCD_ADDR_COLOR: color_q <= reg_wdata_i[15:0];
                    default: ; // ctrl self-clears, status is read only
                endcase
            end
        end
    end

    // finished frames, wraps at 16 bits
    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            frame_cnt <= '0;
        end else if (cfg.frame_done) begin
            frame_cnt <= frame_cnt + 16'd1;
        end
    end

    always_comb begin
        case (reg_addr_i)
            `LCD_ADDR_X0:     reg_rdata_o = {{(32-`LCD_COORD_W){1'b0}}, x0_q};
            `LCD_ADDR_X1:     reg_rdata_o = {{(32-`LCD_COORD_W){1'b0}}, x1_q};
            `LCD_ADDR_Y0:     reg_rdata_o = {{(32-`LCD_COORD_W){1'b0}}, y0_q};
            `LCD_ADDR_Y1:     reg_rdata_o = {{(32-`LCD_COORD_W){1'b0}}, y1_q};
            `LCD_ADDR_COLOR:  reg_rdata_o = {16'h0000, color_q};
            `LCD_ADDR_STATUS: reg_rdata_o = {frame_cnt, 15'h0000, cfg.busy};
            default:          reg_rdata_o = 32'h0000_0000;
        endcase
    end

    assign cfg.x0    = x0_q;
    assign cfg.x1    = x1_q;
    assign cfg.y0    = y0_q;
    assign cfg.y1    = y1_q;
    assign cfg.color = color_q;
    assign cfg.start = start_q;

endmodule

// File: design/lcd_seq_ctrl.sv
// drawing sequencer for window commands, their parameters and the pixel stream
`timescale 1ns/100ps
`include "lcd_defines.svh"

module lcd_seq_ctrl (
    input  logic    pclk,
    input  logic    rst_n_i,
    lcd_cfg_if.seq  cfg,
    lcd_word_if.src word
);

    localparam int CNT_W = 2 * (`LCD_COORD_W + 1);

    lcd_pkg::seq_state_t state;

    logic [`LCD_COORD_W-1:0] wx0;
    logic [`LCD_COORD_W-1:0] wx1;
    logic [`LCD_COORD_W-1:0] wy0;
    logic [`LCD_COORD_W-1:0] wy1;
    logic [15:0]             wcolor;
    logic [`LCD_COORD_W:0]   span_x;
    logic [`LCD_COORD_W:0]   span_y;
    logic [CNT_W-1:0]        npix;
    logic [CNT_W-1:0]        pix_left;
    logic                    par_hi; // second word of a parameter pair
    logic                    xfer;

    // a reversed window gives a zero span
    assign span_x = (cfg.x1 >= cfg.x0) ? ({1'b0, cfg.x1} - {1'b0, cfg.x0} + 1'b1) : '0;
    assign span_y = (cfg.y1 >= cfg.y0) ? ({1'b0, cfg.y1} - {1'b0, cfg.y0} + 1'b1) : '0;
    assign npix   = span_x * span_y;

    assign xfer = word.valid && word.ready;

    always_ff @(posedge pclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= lcd_pkg::IDLE;
            pix_left <= '0;
            par_hi   <= 1'b0;
        end else begin
            case (state)
                lcd_pkg::IDLE: begin
                    par_hi <= 1'b0;
                    if (cfg.start) begin
                        pix_left <= npix;
                        state    <= lcd_pkg::COL_CMD;
                    end
                end
                lcd_pkg::COL_CMD: if (xfer) state <= lcd_pkg::COL_PAR;
                lcd_pkg::COL_PAR: begin
                    if (xfer) begin
                        par_hi <= !par_hi;
                        if (par_hi) state <= lcd_pkg::ROW_CMD;
                    end
                end
                lcd_pkg::ROW_CMD: if (xfer) state <= lcd_pkg::ROW_PAR;
                lcd_pkg::ROW_PAR: begin
                    if (xfer) begin
                        par_hi <= !par_hi;
                        if (par_hi) state <= lcd_pkg::MEM_CMD;
                    end
                end
                lcd_pkg::MEM_CMD: begin
                    if (xfer) begin
                        state <= (pix_left == '0) ? lcd_pkg::DONE : lcd_pkg::PIXELS;
                    end
                end
                lcd_pkg::PIXELS: begin
                    if (xfer) begin
                        pix_left <= pix_left - 1'b1;
                        if (pix_left == CNT_W'(1)) state <= lcd_pkg::DONE;
                    end
                end
                default: state <= lcd_pkg::IDLE; // DONE lasts one cycle
            endcase
        end
    end

    // window and color captured once per frame
    always_ff @(posedge pclk) begin
        if (state == lcd_pkg::IDLE && cfg.start) begin
            wx0    <= cfg.x0;
            wx1    <= cfg.x1;
            wy0    <= cfg.y0;
            wy1    <= cfg.y1;
            wcolor <= cfg.color;
        end
    end

    always_comb begin
        case (state)
            lcd_pkg::COL_CMD: word.data = `LCD_CMD_COL;
            lcd_pkg::COL_PAR: word.data = {{(16-`LCD_COORD_W){1'b0}}, par_hi ? wx1 : wx0};
            lcd_pkg::ROW_CMD: word.data = `LCD_CMD_ROW;
            lcd_pkg::ROW_PAR: word.data = {{(16-`LCD_COORD_W){1'b0}}, par_hi ? wy1 : wy0};
            lcd_pkg::MEM_CMD: word.data = `LCD_CMD_MEMWR;
            lcd_pkg::PIXELS:  word.data = wcolor;
            default:          word.data = 16'h0000;
        endcase
    end

    assign word.valid = (state != lcd_pkg::IDLE) && (state != lcd_pkg::DONE);
    assign word.rs    = (state == lcd_pkg::COL_PAR) || (state == lcd_pkg::ROW_PAR) ||
                        (state == lcd_pkg::PIXELS);

    assign cfg.busy       = (state != lcd_pkg::IDLE);
    assign cfg.frame_done = (state == lcd_pkg::DONE);

endmodule

// File: design/lcd_subsys_top.sv
// top level joining register block, sequencer and bus writer
`timescale 1ns/100ps

module lcd_subsys_top (
    input  logic             pclk,
    input  logic             rst_n_i,
    input  logic             reg_valid_i,
    input  lcd_pkg::reg_op_t reg_op_i,
    input  logic [3:0]       reg_addr_i,
    input  logic [31:0]      reg_wdata_i,
    output logic             reg_ready_o,
    output logic [31:0]      reg_rdata_o,
    output logic             lcd_cs_n_o,
    output logic             lcd_wr_n_o,
    output logic             lcd_rs_o,
    output logic [15:0]      lcd_db_o,
    output logic             busy_o
);

    lcd_cfg_if  cfg_if ();
    lcd_word_if word_if ();

    lcd_regs u_regs (
        .pclk        (pclk),
        .rst_n_i     (rst_n_i),
        .reg_valid_i (reg_valid_i),
        .reg_op_i    (reg_op_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_ready_o (reg_ready_o),
        .reg_rdata_o (reg_rdata_o),
        .cfg         (cfg_if.regs)
    );

    lcd_seq_ctrl u_seq (
        .pclk    (pclk),
        .rst_n_i (rst_n_i),
        .cfg     (cfg_if.seq),
        .word    (word_if.src)
    );

    lcd_bus_writer u_writer (
        .pclk       (pclk),
        .rst_n_i    (rst_n_i),
        .word       (word_if.snk),
        .lcd_cs_n_o (lcd_cs_n_o),
        .lcd_wr_n_o (lcd_wr_n_o),
        .lcd_rs_o   (lcd_rs_o),
        .lcd_db_o   (lcd_db_o)
    );

    assign busy_o = cfg_if.busy; // frame in progress

endmodule

// File: design/lcd_word_if.sv
// interface for one panel bus word with valid/ready handshake
`timescale 1ns/100ps

interface lcd_word_if;

    logic        valid;
    logic        ready;
    logic        rs;   // 0 command, 1 data
    logic [15:0] data;

    // word producer, holds everything until accepted
    modport src (
        output valid,
        output rs,
        output data,
        input  ready
    );

    // word consumer
    modport snk (
        input  valid,
        input  rs,
        input  data,
        output ready
    );

endinterface

// File: dv/tb_lcd_subsys.sv
// testbench with clock, reset, LCG windows, bus reference model and assertions
`timescale 1ns/100ps
`include "lcd_defines.svh"

module tb_lcd_subsys;

    localparam int TIMEOUT_CYC = 400;

    logic             pclk;
    logic             rst_n_i;
    logic             reg_valid_i;
    lcd_pkg::reg_op_t reg_op_i;
    logic [3:0]       reg_addr_i;
    logic [31:0]      reg_wdata_i;
    logic             reg_ready_o;
    logic [31:0]      reg_rdata_o;
    logic             lcd_cs_n_o;
    logic             lcd_wr_n_o;
    logic             lcd_rs_o;
    logic [15:0]      lcd_db_o;
    logic             busy_o;

    logic [16:0] exp_q[$]; // {rs, data} in bus order
    logic [16:0] exp_word;
    logic        wr_prev;
    logic [31:0] rng;
    logic [31:0] last_rdata;
    logic        last_busy;  // busy_o on the completing edge
    int          last_wait;  // cycles until the access completed
    int          check_errs;
    int          bus_errs;
    int          protocol_errs;
    int          timeouts;
    int          frames;

    lcd_subsys_top dut0 (
        .pclk        (pclk),
        .rst_n_i     (rst_n_i),
        .reg_valid_i (reg_valid_i),
        .reg_op_i    (reg_op_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_ready_o (reg_ready_o),
        .reg_rdata_o (reg_rdata_o),
        .lcd_cs_n_o  (lcd_cs_n_o),
        .lcd_wr_n_o  (lcd_wr_n_o),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_db_o    (lcd_db_o),
        .busy_o      (busy_o)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    // panel side model latches a word when wr_n rises with cs_n low
    always @(posedge pclk) begin
        wr_prev <= lcd_wr_n_o;
        if (rst_n_i && lcd_wr_n_o && !wr_prev && !lcd_cs_n_o) begin
            if (exp_q.size() == 0) begin
                bus_errs++;
                $display("Word %h with rs %b at %0t was not expected", lcd_db_o, lcd_rs_o, $time);
            end else begin
                exp_word = exp_q.pop_front();
                assert (lcd_rs_o === exp_word[16]) else begin
                    bus_errs++;
                    $display("Error at %0t: lcd_rs_o is %b, expected %b",
                             $time, lcd_rs_o, exp_word[16]);
                end
                assert (lcd_db_o === exp_word[15:0]) else begin
                    bus_errs++;
                    $display("Error at %0t: lcd_db_o is %h, expected %h",
                             $time, lcd_db_o, exp_word[15:0]);
                end
            end
        end
    end

    wr_low_width: assert property (@(posedge pclk) disable iff (!rst_n_i)
        $rose(lcd_wr_n_o) |-> !$past(lcd_wr_n_o, 2) && $past(lcd_wr_n_o, 3))
    else begin
        protocol_errs++;
        $display("wr_n low phase ending at %0t was not %0d cycles", $time, `LCD_WR_LOW_CYC);
    end

    wr_high_width: assert property (@(posedge pclk) disable iff (!rst_n_i)
        $fell(lcd_wr_n_o) |-> $past(lcd_wr_n_o, 2))
    else begin
        protocol_errs++;
        $display("wr_n high phase before %0t was shorter than %0d cycles",
                 $time, `LCD_WR_HIGH_CYC);
    end

    bus_hold: assert property (@(posedge pclk) disable iff (!rst_n_i)
        !lcd_wr_n_o && !$fell(lcd_wr_n_o) |-> $stable(lcd_rs_o) && $stable(lcd_db_o))
    else begin
        protocol_errs++;
        $display("rs or db changed while wr_n was low at %0t", $time);
    end

    // window, color and ctrl writes wait out the frame
    cfg_stall: assert property (@(posedge pclk) disable iff (!rst_n_i)
        reg_valid_i && reg_op_i == lcd_pkg::OP_WRITE && reg_addr_i <= `LCD_ADDR_CTRL && busy_o
        |-> !reg_ready_o)
    else begin
        protocol_errs++;
        $display("Error at %0t: reg_ready_o is 1, expected 0 while busy_o is high", $time);
    end

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return {16'h0000, rng[31:16]};
    endfunction

    function automatic int pixel_count(input int x0, input int x1, input int y0, input int y1);
        if (x1 < x0 || y1 < y0) return 0;
        return (x1 - x0 + 1) * (y1 - y0 + 1);
    endfunction

    task automatic end_run();
        $display("errors: checks %0d, bus words %0d, protocol %0d, timeouts %0d",
                 check_errs, bus_errs, protocol_errs, timeouts);
        if (check_errs + bus_errs + protocol_errs + timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic abort_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        end_run();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        check_errs++;
        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // one host access held until an edge with ready high
    task automatic reg_access(input lcd_pkg::reg_op_t op, input logic [3:0] addr,
                              input logic [31:0] wdata);
        @(posedge pclk);
        reg_valid_i <= 1'b1;
        reg_op_i    <= op;
        reg_addr_i  <= addr;
        reg_wdata_i <= wdata;
        last_wait = 0;
        do begin
            @(posedge pclk);
            last_wait++;
            if (last_wait > TIMEOUT_CYC) abort_timeout("register port ready");
        end while (!reg_ready_o);
        last_rdata = reg_rdata_o;
        last_busy  = busy_o;
        reg_valid_i <= 1'b0;
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy_o !== level) begin
            @(posedge pclk);
            n++;
            if (n > TIMEOUT_CYC) abort_timeout("busy_o to change");
        end
    endtask

    // last word on the bus is captured before cs_n rises
    task automatic wait_bus_idle();
        int n;
        n = 0;
        while (lcd_cs_n_o !== 1'b1) begin
            @(posedge pclk);
            n++;
            if (n > TIMEOUT_CYC) abort_timeout("cs_n to rise");
        end
    endtask

    task automatic run_frame(input int x0, input int x1, input int y0, input int y1,
                             input int color, input bit stall);
        int npix;
        int i;
        npix = pixel_count(x0, x1, y0, y1);
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_X0, 32'(x0));
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_X1, 32'(x1));
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_Y0, 32'(y0));
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_Y1, 32'(y1));
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_COLOR, 32'(color));
        exp_q.push_back({1'b0, `LCD_CMD_COL});
        exp_q.push_back({1'b1, 16'(x0)});
        exp_q.push_back({1'b1, 16'(x1)});
        exp_q.push_back({1'b0, `LCD_CMD_ROW});
        exp_q.push_back({1'b1, 16'(y0)});
        exp_q.push_back({1'b1, 16'(y1)});
        exp_q.push_back({1'b0, `LCD_CMD_MEMWR});
        for (i = 0; i < npix; i++) exp_q.push_back({1'b1, 16'(color)});
        reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_CTRL, 32'd1);
        wait_busy(1'b1);
        if (stall) begin
            reg_access(lcd_pkg::OP_READ, `LCD_ADDR_STATUS, 32'd0);
            assert (last_wait == 1) else begin
                check_errs++;
                $display("STATUS read during a frame took %0d cycles", last_wait);
            end
            assert (last_rdata[0] === 1'b1) else
                report_mismatch("reg_rdata_o[0]", last_rdata[0], 1);
            reg_access(lcd_pkg::OP_WRITE, `LCD_ADDR_X0, 32'(x0 + 1));
            assert (last_busy === 1'b0) else begin
                check_errs++;
                $display("window write at %0t completed while the frame was drawing", $time);
            end
        end
        wait_busy(1'b0);
        wait_bus_idle();
        assert (exp_q.size() == 0) else begin
            check_errs++;
            $display("%0d expected words never reached the bus by %0t", exp_q.size(), $time);
            exp_q.delete();
        end
        frames++;
        if (stall) begin
            reg_access(lcd_pkg::OP_READ, `LCD_ADDR_X0, 32'd0);
            assert (last_rdata == 32'(x0 + 1)) else
                report_mismatch("reg_rdata_o", last_rdata, x0 + 1);
        end
    endtask

    // windows of at most 4 by 3 pixels inside the coordinate range
    task automatic random_frame(input bit stall);
        int x0;
        int y0;
        int w;
        int h;
        int color;
        x0    = int'(next_rand() % 1000);
        y0    = int'(next_rand() % 1000);
        w     = 1 + int'(next_rand() % 4);
        h     = 1 + int'(next_rand() % 3);
        color = int'(next_rand());
        run_frame(x0, x0 + w - 1, y0, y0 + h - 1, color, stall);
    endtask

    initial begin
        int a;
        rst_n_i     = 1'b0;
        reg_valid_i = 1'b0;
        reg_op_i    = lcd_pkg::OP_READ;
        reg_addr_i  = 4'd0;
        reg_wdata_i = 32'd0;
        rng         = 32'hcc68_e67d;
        check_errs    = 0;
        bus_errs      = 0;
        protocol_errs = 0;
        timeouts      = 0;
        frames        = 0;
        repeat (5) @(posedge pclk);
        rst_n_i <= 1'b1;
        @(posedge pclk);
        @(posedge pclk);
        assert (lcd_cs_n_o === 1'b1) else report_mismatch("lcd_cs_n_o", lcd_cs_n_o, 1);
        assert (lcd_wr_n_o === 1'b1) else report_mismatch("lcd_wr_n_o", lcd_wr_n_o, 1);
        assert (busy_o === 1'b0) else report_mismatch("busy_o", busy_o, 0);
        assert (reg_ready_o === 1'b1) else report_mismatch("reg_ready_o", reg_ready_o, 1);
        for (a = 0; a <= 6; a++) begin
            reg_access(lcd_pkg::OP_READ, 4'(a), 32'd0);
            assert (last_rdata === 32'd0) else report_mismatch("reg_rdata_o", last_rdata, 0);
        end
        run_frame(5, 3, 7, 8, 16'hbeef, 1'b0); // reversed x gives no pixels
        run_frame(2, 4, 9, 6, 16'h1234, 1'b0); // reversed y gives no pixels
        for (a = 0; a < 6; a++) random_frame(a == 2);
        reg_access(lcd_pkg::OP_READ, `LCD_ADDR_STATUS, 32'd0);
        assert (last_rdata[31:16] == 16'(frames)) else
            report_mismatch("reg_rdata_o[31:16]", last_rdata[31:16], frames);
        end_run();
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and search its output for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_lcd_subsys -f vlog.f -o sim_lcd_subsys || exit 1
result=$(./obj_dir/sim_lcd_subsys) || true
echo "$result"
echo "$result" | grep -qx "TB PASSED" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// File: vlog.f
+incdir+design
design/lcd_pkg.sv
design/lcd_word_if.sv
design/lcd_cfg_if.sv
design/lcd_regs.sv
design/lcd_seq_ctrl.sv
design/lcd_bus_writer.sv
design/lcd_subsys_top.sv
dv/tb_lcd_subsys.sv
